// File: Bender.yml
package:
  name: cpu_accumulator

sources:
  - include_dirs:
      - .
    files:
      - cpuPkg.sv
      - cpuDecode.sv
      - cpuExecute.sv
      - cpuBusResult.sv
      - cpuTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

// File: cpuBusResult.sv
`include "cpu_defines.svh"

module cpuBusResult import cpuPkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    input  stateT                  state,
    input  romWordT                romData,
    input  logic [`CPU_DATA_W-1:0] regA,
    input  logic [`CPU_DATA_W-1:0] regB,
    output logic [`CPU_DATA_W-1:0] busAddr,
    output logic [`CPU_DATA_W-1:0] busDataOut,
    output logic                   busWe
);

    // Address and strobe
    // operand byte of a load or store goes out for one cycle, else idle address
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= `CPU_BUS_IDLE_ADDR;
            busWe   <= 1'b0;
        end else begin
            busAddr <= `CPU_BUS_IDLE_ADDR;
            busWe   <= 1'b0;
            case (state)
                stLoadAddrA, stLoadAddrB: begin
                    busAddr <= romData.addr;
                end
                stStoreWriteA, stStoreWriteB: begin
                    busAddr <= romData.addr;
                    busWe   <= 1'b1;
                end
                default: begin
                    busAddr <= `CPU_BUS_IDLE_ADDR;
                end
            endcase
        end
    end

    // Write data, A or B picked by the store state
    always_ff @(posedge CLK) begin
        if (state == stStoreWriteA) begin
            busDataOut <= regA;
        end else if (state == stStoreWriteB) begin
            busDataOut <= regB;
        end
    end

    // Writes land on a real address and never run two cycles long
    weAddr: assert property (@(posedge CLK) disable iff (RESET)
        busWe |-> (busAddr != `CPU_BUS_IDLE_ADDR) ##1 !busWe);

endmodule

// File: cpuDecode.sv
`include "cpu_defines.svh"

module cpuDecode import cpuPkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    input  romWordT                romData,
    input  logic [1:0]             interruptRaise,
    input  logic                   aluFlag,
    output logic [`CPU_DATA_W-1:0] romAddress,
    output logic [1:0]             interruptAck,
    output stateT                  state
);

    // Program counter plus operand offset
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] pcNext;
    logic                   offset;
    logic                   offsetNext;
    stateT                  stateNext;
    logic [1:0]             ackNext;

    // ROM read is registered, so data shows up one cycle after this address
    assign romAddress = pc + {{(`CPU_DATA_W-1){1'b0}}, offset};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= stChoose;
            pc           <= '0;
            offset       <= 1'b0;
            interruptAck <= 2'b00;
        end else begin
            state        <= stateNext;
            pc           <= pcNext;
            offset       <= offsetNext;
            interruptAck <= ackNext;
        end
    end

    always_comb begin
        // Hold by default, offset back to the opcode byte
        stateNext  = state;
        pcNext     = pc;
        offsetNext = 1'b0;
        ackNext    = 2'b00;

        case (state)
            //////////////////////////////
            // Thread entry
            //////////////////////////////
            // Line 0 wins when both are raised
            stIdle: begin
                if (interruptRaise[0]) begin
                    stateNext = stThread0;
                    pcNext    = `CPU_VECTOR_0;
                    ackNext   = 2'b01;
                end else if (interruptRaise[1]) begin
                    stateNext = stThread0;
                    pcNext    = `CPU_VECTOR_1;
                    ackNext   = 2'b10;
                end
            end
            // Vector address on the ROM port
            stThread0: stateNext = stThread1;
            // Vector contents arrive, jump there
            stThread1: begin
                stateNext = stThread2;
                pcNext    = romData.addr;
            end
            // First opcode of the thread in flight
            stThread2: stateNext = stChoose;

            //////////////////////////////
            // Opcode dispatch
            //////////////////////////////
            stChoose: begin
                offsetNext = 1'b1;
                case (romData.instr.opcode)
                    opLoadA:  stateNext = stLoadA;
                    opLoadB:  stateNext = stLoadB;
                    opStoreA: stateNext = stStoreA;
                    opStoreB: stateNext = stStoreB;
                    opAluA:   stateNext = stAluA;
                    opAluB:   stateNext = stAluB;
                    opBranch: stateNext = stBranch;
                    opGoto:   stateNext = stGoto;
                    opIdle:   stateNext = stIdle;
                    // Unknown opcode parks here on the same byte
                    default:  offsetNext = 1'b0;
                endcase
            end

            //////////////////////////////
            // Loads
            //////////////////////////////
            // Operand byte on its way
            stLoadA: stateNext = stLoadAddrA;
            stLoadB: stateNext = stLoadAddrB;
            // Result stage latches the bus address now
            stLoadAddrA: stateNext = stLoadWaitA;
            stLoadAddrB: stateNext = stLoadWaitB;
            // Step past opcode and operand, two cycles before choose
            stLoadWaitA: begin
                stateNext = stLoadDoneA;
                pcNext    = pc + 2'd2;
            end
            stLoadWaitB: begin
                stateNext = stLoadDoneB;
                pcNext    = pc + 2'd2;
            end
            // Execute takes the RAM byte here
            stLoadDoneA: stateNext = stChoose;
            stLoadDoneB: stateNext = stChoose;

            //////////////////////////////
            // Stores
            //////////////////////////////
            stStoreA: begin
                stateNext = stStoreWriteA;
                pcNext    = pc + 2'd2;
            end
            stStoreB: begin
                stateNext = stStoreWriteB;
                pcNext    = pc + 2'd2;
            end
            // Operand byte valid, result stage issues the write
            stStoreWriteA: stateNext = stChoose;
            stStoreWriteB: stateNext = stChoose;

            //////////////////////////////
            // ALU and flow control
            //////////////////////////////
            // Execute saves the ALU result in these states
            stAluA: begin
                stateNext = stAluWait;
                pcNext    = pc + 1'b1;
            end
            stAluB: begin
                stateNext = stAluWait;
                pcNext    = pc + 1'b1;
            end
            stAluWait: stateNext = stChoose;

            // Flag comes from the compare code in the branch opcode
            stBranch: begin
                if (aluFlag) begin
                    stateNext = stBranchJump;
                end else begin
                    stateNext = stBranchWait;
                    pcNext    = pc + 2'd2;
                end
            end
            stBranchJump: begin
                stateNext = stBranchWait;
                pcNext    = romData.addr;
            end
            stBranchWait: stateNext = stChoose;

            stGoto: stateNext = stGotoJump;
            stGotoJump: begin
                stateNext = stGotoWait;
                pcNext    = romData.addr;
            end
            stGotoWait: stateNext = stChoose;

            default: stateNext = state;
        endcase
    end

    // Ack is a single one-hot pulse, never repeated back to back
    ackPulse: assert property (@(posedge CLK) disable iff (RESET)
        (interruptAck != 2'b00) |-> $onehot(interruptAck) ##1 (interruptAck == 2'b00));

    // State register stays inside the encoded set
    stateLegal: assert property (@(posedge CLK) disable iff (RESET)
        !$isunknown(state) && (state <= stGotoWait));

endmodule

// File: cpuExecute.sv
`include "cpu_defines.svh"

module cpuExecute import cpuPkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    input  stateT                  state,
    input  romWordT                romData,
    input  logic [`CPU_DATA_W-1:0] busDataIn,
    output logic [`CPU_DATA_W-1:0] regA,
    output logic [`CPU_DATA_W-1:0] regB,
    output logic                   aluFlag
);

    logic [`CPU_DATA_W-1:0] aluOut;

    //////////////////////////////
    // ALU
    //////////////////////////////
    // Function from the high nibble of the current instruction byte
    always_comb begin
        aluOut = '0;
        case (romData.instr.aluOp)
            aluAdd: aluOut = regA + regB;
            aluSub: aluOut = regA - regB;
            aluAnd: aluOut = regA & regB;
            aluOr:  aluOut = regA | regB;
            aluXor: aluOut = regA ^ regB;
            aluShl: aluOut = regA << 1;
            aluShr: aluOut = regA >> 1;
            aluInc: aluOut = regA + 1'b1;
            // Compares give 1 or 0
            aluEq:  aluOut[0] = (regA == regB);
            aluGt:  aluOut[0] = (regA > regB);
            aluLt:  aluOut[0] = (regA < regB);
            // Unused codes give 0
            default: aluOut = '0;
        endcase
    end

    // Branch condition, only meaningful for compare codes
    assign aluFlag = aluOut[0];

    //////////////////////////////
    // Register file
    //////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
        end else begin
            case (state)
                // ALU result, instruction byte still on romData
                stAluA: regA <= aluOut;
                stAluB: regB <= aluOut;
                // RAM data back two cycles after the address was latched
                stLoadDoneA: regA <= busDataIn;
                stLoadDoneB: regB <= busDataIn;
                default: begin
                    regA <= regA;
                    regB <= regB;
                end
            endcase
        end
    end

endmodule

// File: cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    // Operation code, low nibble of an instruction byte
    // Codes 9 to F are not decoded
    typedef enum logic [3:0] {
        opLoadA  = 4'h0,
        opLoadB  = 4'h1,
        opStoreA = 4'h2,
        opStoreB = 4'h3,
        opAluA   = 4'h4,
        opAluB   = 4'h5,
        opBranch = 4'h6,
        opGoto   = 4'h7,
        opIdle   = 4'h8
    } opcodeT;

    // ALU function, high nibble of an instruction byte
    // Compare codes return 1 or 0 in bit 0
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluSub = 4'h1,
        aluAnd = 4'h2,
        aluOr  = 4'h3,
        aluXor = 4'h4,
        aluShl = 4'h5,
        aluShr = 4'h6,
        aluInc = 4'h7,
        aluEq  = 4'h8,
        aluGt  = 4'h9,
        aluLt  = 4'hA
    } aluOpT;

    // One ROM byte, read as an instruction at offset 0
    // and as an address operand at offset 1
    typedef union packed {
        struct packed {
            aluOpT  aluOp;
            opcodeT opcode;
        } instr;
        logic [`CPU_DATA_W-1:0] addr;
    } romWordT;

    // Sequencer states, one chain per operation
    // stGotoWait must stay the last member
    typedef enum logic [4:0] {
        stIdle, stThread0, stThread1, stThread2,
        stChoose,
        stLoadA, stLoadAddrA, stLoadWaitA, stLoadDoneA,
        stLoadB, stLoadAddrB, stLoadWaitB, stLoadDoneB,
        stStoreA, stStoreWriteA, stStoreB, stStoreWriteB,
        stAluA, stAluB, stAluWait,
        stBranch, stBranchJump, stBranchWait,
        stGoto, stGotoJump, stGotoWait
    } stateT;

endpackage

// File: cpuTop.sv
`include "cpu_defines.svh"

module cpuTop import cpuPkg::*; (
    input  logic                   CLK,
    input  logic                   RESET,
    output logic [`CPU_DATA_W-1:0] romAddress,
    input  logic [`CPU_DATA_W-1:0] romData,
    output logic [`CPU_DATA_W-1:0] busAddr,
    output logic [`CPU_DATA_W-1:0] busDataOut,
    input  logic [`CPU_DATA_W-1:0] busDataIn,
    output logic                   busWe,
    input  logic [1:0]             interruptRaise,
    output logic [1:0]             interruptAck
);

    // Sequencer state shared by all three stages
    stateT                  state;
    logic                   aluFlag;
    logic [`CPU_DATA_W-1:0] regA;
    logic [`CPU_DATA_W-1:0] regB;

    // Sequencer, program counter and interrupt handshake
    cpuDecode decode (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .interruptRaise (interruptRaise),
        .aluFlag        (aluFlag),
        .romAddress     (romAddress),
        .interruptAck   (interruptAck),
        .state          (state)
    );

    // Registers and ALU
    cpuExecute execute (
        .CLK       (CLK),
        .RESET     (RESET),
        .state     (state),
        .romData   (romData),
        .busDataIn (busDataIn),
        .regA      (regA),
        .regB      (regB),
        .aluFlag   (aluFlag)
    );

    // Bus output registers
    cpuBusResult result (
        .CLK        (CLK),
        .RESET      (RESET),
        .state      (state),
        .romData    (romData),
        .regA       (regA),
        .regB       (regB),
        .busAddr    (busAddr),
        .busDataOut (busDataOut),
        .busWe      (busWe)
    );

endmodule

// File: cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////
// Datapath sizing
//////////////////////////////

// Width of data bytes, bus addresses, ROM addresses and ROM words
`define CPU_DATA_W 8

//////////////////////////////
// Fixed addresses
//////////////////////////////

// ROM location holding the thread start address for interrupt line 0
`define CPU_VECTOR_0 8'hFF

// ROM location holding the thread start address for interrupt line 1
`define CPU_VECTOR_1 8'hFE

// Bus address driven while no load or store is in progress
// RAM at this address should never be written
`define CPU_BUS_IDLE_ADDR 8'hFF

`endif

// File: tb.f
+incdir+.
cpuPkg.sv
cpuDecode.sv
cpuExecute.sv
cpuBusResult.sv
cpuTop.sv
tb_cpu.sv

// File: tb_cpu.sv
`include "cpu_defines.svh"

module tb_cpu import cpuPkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   CLK = 1'b0;
    logic                   RESET = 1'b1;
    logic [`CPU_DATA_W-1:0] romAddress;
    logic [`CPU_DATA_W-1:0] romData = '0;
    logic [`CPU_DATA_W-1:0] busAddr;
    logic [`CPU_DATA_W-1:0] busDataOut;
    logic [`CPU_DATA_W-1:0] busDataIn = '0;
    logic                   busWe;
    logic [1:0]             interruptRaise = 2'b00;
    logic [1:0]             interruptAck;

    // Program ROM, bus RAM and the model's private RAM copy
    logic [7:0]  rom [0:255];
    logic [7:0]  ram [0:255];
    logic [7:0]  modelRam [0:255];
    logic [7:0]  modelA;
    logic [7:0]  modelB;
    logic [7:0]  romPtr;
    logic [31:0] rngState = 32'hf2b5a73b;

    // Expected stores in program order
    logic [7:0]  expAddrQ [$];
    logic [7:0]  expDataQ [$];

    // Watchdog bookkeeping
    int          cycleCount = 0;
    int          instrTotal = 0;

    cpuTop uut (
        .CLK            (CLK),
        .RESET          (RESET),
        .romAddress     (romAddress),
        .romData        (romData),
        .busAddr        (busAddr),
        .busDataOut     (busDataOut),
        .busDataIn      (busDataIn),
        .busWe          (busWe),
        .interruptRaise (interruptRaise),
        .interruptAck   (interruptAck)
    );

    always #4 CLK = ~CLK;

    //////////////////////////////
    // Memory models
    //////////////////////////////
    // Both have one cycle of read latency
    always @(posedge CLK) begin
        romData <= rom[romAddress];
    end

    always @(posedge CLK) begin
        if (busWe) begin
            ram[busAddr] <= busDataOut;
        end
        busDataIn <= ram[busAddr];
    end

    //////////////////////////////
    // Failure handling
    //////////////////////////////
    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkAddr(input string name, input logic [`CPU_DATA_W-1:0] got,
                             input logic [`CPU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            failRun("Address differs from the expected value");
        end
    endtask

    task automatic checkData(input string name, input logic [`CPU_DATA_W-1:0] got,
                             input logic [`CPU_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            failRun("Stored byte differs from the model");
        end
    endtask

    task automatic checkAck(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            failRun("Interrupt acknowledge is wrong");
        end
    endtask

    // Budget of 20 cycles per executed instruction on top of 200
    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > 200 + 20 * instrTotal) begin
            failRun("Timeout: the DUT did not finish the programs in time");
        end
    end

    // Every write strobe must match the next expected store
    always @(negedge CLK) begin
        if (!RESET && busWe === 1'b1) begin
            if (expAddrQ.size() == 0) begin
                failRun("Bus write seen when no store was expected");
            end else begin
                checkAddr("busAddr", busAddr, expAddrQ.pop_front());
                checkData("busDataOut", busDataOut, expDataQ.pop_front());
            end
        end
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ALU table, compare codes give 1 or 0, unused codes 0
    function automatic logic [7:0] aluExpect(input logic [3:0] code, input logic [7:0] a,
                                             input logic [7:0] b);
        case (code)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return a & b;
            4'h3: return a | b;
            4'h4: return a ^ b;
            4'h5: return {a[6:0], 1'b0};
            4'h6: return {1'b0, a[7:1]};
            4'h7: return a + 8'd1;
            4'h8: return (a == b) ? 8'd1 : 8'd0;
            4'h9: return (a > b) ? 8'd1 : 8'd0;
            4'hA: return (a < b) ? 8'd1 : 8'd0;
            default: return 8'd0;
        endcase
    endfunction

    // Walk the ROM from startPc up to idle and queue each store
    // Returns the number of instructions executed
    function automatic int predictStores(input logic [7:0] startPc);
        logic [7:0] pc;
        logic [7:0] operand;
        logic [7:0] aluRes;
        romWordT    w;
        int         steps;
        pc = startPc;
        steps = 0;
        while (steps < 500) begin
            w = rom[pc];
            operand = rom[pc + 8'd1];
            aluRes = aluExpect(w.instr.aluOp, modelA, modelB);
            steps++;
            case (w.instr.opcode)
                opLoadA: begin
                    modelA = modelRam[operand];
                    pc = pc + 8'd2;
                end
                opLoadB: begin
                    modelB = modelRam[operand];
                    pc = pc + 8'd2;
                end
                opStoreA, opStoreB: begin
                    modelRam[operand] = (w.instr.opcode == opStoreA) ? modelA : modelB;
                    expAddrQ.push_back(operand);
                    expDataQ.push_back(modelRam[operand]);
                    pc = pc + 8'd2;
                end
                opAluA: begin
                    modelA = aluRes;
                    pc = pc + 8'd1;
                end
                opAluB: begin
                    modelB = aluRes;
                    pc = pc + 8'd1;
                end
                opBranch: begin
                    pc = aluRes[0] ? operand : pc + 8'd2;
                end
                opGoto: pc = operand;
                // Idle, and illegal codes which park the sequencer
                default: return steps;
            endcase
        end
        return steps;
    endfunction

    //////////////////////////////
    // Program building
    //////////////////////////////
    task automatic putOp(input opcodeT op, input aluOpT alu);
        romWordT w;
        w.instr.opcode = op;
        w.instr.aluOp = alu;
        rom[romPtr] = w.addr;
        romPtr = romPtr + 8'd1;
    endtask

    task automatic putOpAddr(input opcodeT op, input aluOpT alu, input logic [7:0] operand);
        putOp(op, alu);
        rom[romPtr] = operand;
        romPtr = romPtr + 8'd1;
    endtask

    // Hold reset while ROM and RAM are rebuilt
    task automatic startTest(input string name);
        romWordT idleWord;
        idleWord.instr.opcode = opIdle;
        idleWord.instr.aluOp = aluAdd;
        @(posedge CLK);
        #1;
        RESET = 1'b1;
        interruptRaise = 2'b00;
        $display("Test: %s", name);
        for (int i = 0; i < 256; i++) begin
            rngState = xorshift32(rngState);
            ram[i] = rngState[15:8];
            modelRam[i] = rngState[15:8];
            rom[i] = idleWord.addr;
        end
        expAddrQ.delete();
        expDataQ.delete();
        modelA = 8'h00;
        modelB = 8'h00;
        romPtr = 8'h00;
    endtask

    // Predict the main program, then finish the 5 reset cycles
    task automatic releaseReset();
        instrTotal += predictStores(8'h00);
        repeat (4) @(posedge CLK);
        #1;
        // Reset values: program counter at 0, bus parked, no ack
        checkAddr("romAddress", romAddress, 8'h00);
        checkAddr("busAddr", busAddr, `CPU_BUS_IDLE_ADDR);
        checkAck("interruptAck", interruptAck, 2'b00);
        RESET = 1'b0;
    endtask

    // Run until the sequencer parks in idle, every store must be seen by then
    task automatic waitIdle();
        @(posedge CLK);
        #1;
        while (uut.state != stIdle) begin
            @(posedge CLK);
            #1;
        end
        if (expAddrQ.size() != 0) begin
            failRun("DUT went idle before all expected stores appeared on the bus");
        end
    endtask

    // Raise lines, wait for the ack pulse, drop the acked line
    task automatic serviceInterrupt(input logic [1:0] raiseMask, input logic [1:0] expAck);
        interruptRaise = interruptRaise | raiseMask;
        @(posedge CLK);
        #1;
        while (interruptAck == 2'b00) begin
            @(posedge CLK);
            #1;
        end
        checkAck("interruptAck", interruptAck, expAck);
        interruptRaise = interruptRaise & ~interruptAck;
        // Pulse lasts one cycle only
        @(posedge CLK);
        #1;
        checkAck("interruptAck", interruptAck, 2'b00);
    endtask

    // Main program idles, threads at 80 and A0
    task automatic buildThreadRom();
        putOpAddr(opLoadA, aluAdd, 8'h50);
        putOpAddr(opStoreA, aluAdd, 8'h60);
        putOp(opIdle, aluAdd);
        romPtr = 8'h80;
        putOpAddr(opLoadB, aluAdd, 8'h51);
        putOpAddr(opStoreB, aluAdd, 8'h61);
        putOp(opIdle, aluAdd);
        romPtr = 8'hA0;
        putOp(opAluA, aluAdd);
        putOpAddr(opStoreA, aluAdd, 8'h62);
        putOp(opAluB, aluXor);
        putOpAddr(opStoreB, aluAdd, 8'h63);
        putOp(opIdle, aluAdd);
        rom[`CPU_VECTOR_1] = 8'h80;
        rom[`CPU_VECTOR_0] = 8'hA0;
    endtask

    initial begin
        logic [3:0] nib;

        // Copy bytes around through A and B
        startTest("load and store");
        putOpAddr(opLoadA, aluAdd, 8'h10);
        putOpAddr(opStoreA, aluAdd, 8'h80);
        putOpAddr(opLoadB, aluAdd, 8'h11);
        putOpAddr(opStoreB, aluAdd, 8'h81);
        putOpAddr(opLoadA, aluAdd, 8'h12);
        putOpAddr(opLoadB, aluAdd, 8'h13);
        putOpAddr(opStoreB, aluAdd, 8'h82);
        putOpAddr(opStoreA, aluAdd, 8'h83);
        putOpAddr(opLoadA, aluAdd, 8'h80);
        putOpAddr(opStoreA, aluAdd, 8'h84);
        putOp(opIdle, aluAdd);
        releaseReset();
        waitIdle();

        // All 16 codes into B, then into A
        startTest("ALU codes");
        for (int code = 0; code < 16; code++) begin
            nib = code[3:0];
            putOpAddr(opLoadA, aluAdd, {4'hC, nib});
            // Same source for both so the equal compare is true once
            putOpAddr(opLoadB, aluAdd, (nib == 4'h8) ? {4'hC, nib} : {4'hD, nib});
            putOp(opAluB, aluOpT'(nib));
            putOpAddr(opStoreB, aluAdd, {3'b001, nib, 1'b0});
            putOp(opAluA, aluOpT'(nib));
            putOpAddr(opStoreA, aluAdd, {3'b001, nib, 1'b1});
        end
        putOp(opIdle, aluAdd);
        releaseReset();
        waitIdle();

        // Byte addresses of each instruction noted on the right
        startTest("branch and goto");
        putOpAddr(opLoadA, aluAdd, 8'h40);    // 00
        putOpAddr(opLoadB, aluAdd, 8'h40);    // 02
        putOpAddr(opBranch, aluEq, 8'h08);    // 04 taken
        putOpAddr(opStoreA, aluAdd, 8'h90);   // 06
        putOpAddr(opStoreB, aluAdd, 8'h91);   // 08
        putOpAddr(opBranch, aluLt, 8'h10);    // 0A not taken
        putOpAddr(opStoreA, aluAdd, 8'h92);   // 0C
        putOpAddr(opGoto, aluAdd, 8'h12);     // 0E
        putOpAddr(opStoreA, aluAdd, 8'h93);   // 10
        putOp(opAluA, aluInc);                // 12
        putOpAddr(opBranch, aluGt, 8'h17);    // 13
        putOpAddr(opStoreA, aluAdd, 8'h94);   // 15
        putOpAddr(opStoreB, aluAdd, 8'h95);   // 17
        putOpAddr(opStoreA, aluAdd, 8'h96);   // 19
        putOp(opIdle, aluAdd);                // 1B
        releaseReset();
        waitIdle();

        // Line 1 then line 0, one at a time
        startTest("interrupt threads");
        buildThreadRom();
        releaseReset();
        waitIdle();
        instrTotal += predictStores(rom[`CPU_VECTOR_1]);
        serviceInterrupt(2'b10, 2'b10);
        waitIdle();
        instrTotal += predictStores(rom[`CPU_VECTOR_0]);
        serviceInterrupt(2'b01, 2'b01);
        waitIdle();

        // Both at once, line 0 thread runs first
        startTest("interrupt priority");
        buildThreadRom();
        releaseReset();
        waitIdle();
        instrTotal += predictStores(rom[`CPU_VECTOR_0]);
        instrTotal += predictStores(rom[`CPU_VECTOR_1]);
        serviceInterrupt(2'b11, 2'b01);
        serviceInterrupt(2'b00, 2'b10);
        waitIdle();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
